// File: logic/adder_pkg.sv
package adder_pkg;

	localparam int DATA_W = 32;  // operand and result width
	localparam int LANES  = 4;   // number of adder lanes
	localparam int LANE_W = 2;   // lane index width, log2 of LANES
	localparam int CMD_W  = 5;

	// command codes, anything not listed is invalid
	typedef enum logic [CMD_W-1:0]
	{
		ADD    = 5'h00,
		SUB    = 5'h01,
		NEG    = 5'h02,
		COUT   = 5'h03,  // carry-out only
		SEXT8  = 5'h04,
		SEXT16 = 5'h05,
		MAX    = 5'h06,  // signed
		MIN    = 5'h07,  // signed
		UMAX   = 5'h08,
		UMIN   = 5'h09
	} adder_cmd_e;

	// one operation as it enters the cluster
	typedef struct packed
	{
		adder_cmd_e        cmd;
		logic [DATA_W-1:0] data_0;
		logic [DATA_W-1:0] data_1;
	} adder_req_t;

	typedef struct packed
	{
		logic zf;  // result is zero
		logic pf;  // result bit 0
		logic of;  // signed overflow
		logic sf;  // result sign
		logic cf;  // carry out of bit 31
	} adder_flags_t;

	// result word with its flags
	typedef struct packed
	{
		logic [DATA_W-1:0] data;
		adder_flags_t      flags;
	} adder_rsp_t;

endpackage

// File: logic/adder_dispatch.sv
module adder_dispatch (
	input  logic                             clock,
	input  logic                             arst_n,
	input  logic                             in_valid,
	input  adder_pkg::adder_req_t            in_req,
	output logic                             in_ready,
	output logic [adder_pkg::LANES-1:0]      lane_in_valid,
	output adder_pkg::adder_req_t            lane_req,
	input  logic [adder_pkg::LANES-1:0]      lane_in_ready
);

	import adder_pkg::*;

	logic [LANE_W-1:0] issue_ptr;  // lane whose turn it is
	logic              in_fire;

	// ready follows the lane at the pointer only
	assign in_ready = lane_in_ready[issue_ptr];
	assign in_fire  = in_valid && in_ready;

	// request word goes to every lane, valid to one
	assign lane_req = in_req;

	always_comb
	begin
		lane_in_valid            = '0;
		lane_in_valid[issue_ptr] = in_valid;
	end

	// step to the next lane on each accepted request
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			issue_ptr <= '0;
		end
		else if (in_fire)
		begin
			if (issue_ptr == LANE_W'(LANES - 1))
			begin
				issue_ptr <= '0;  // wrap back to lane 0
			end
			else
			begin
				issue_ptr <= issue_ptr + 1'b1;
			end
		end
	end

endmodule

// File: logic/adder_lane.sv
module adder_lane (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  adder_pkg::adder_req_t req,
	output logic                  in_ready,
	output logic                  out_valid,
	output adder_pkg::adder_rsp_t rsp,
	input  logic                  out_ready
);

	import adder_pkg::*;

	logic [DATA_W:0]   op_0;      // zero-extended, bit 32 catches the carry
	logic [DATA_W:0]   op_1;
	logic [DATA_W:0]   sum;
	logic              is_sub;
	logic              add_of;
	logic              sub_of;
	logic [DATA_W-1:0] neg_data;
	logic [DATA_W-1:0] sext8_data;
	logic [DATA_W-1:0] sext16_data;
	logic              s_ge;      // data_0 >= data_1, signed
	logic              s_le;
	logic              u_ge;      // data_0 >= data_1, unsigned
	logic              u_le;
	adder_flags_t      arith_flags;
	adder_rsp_t        result;
	adder_rsp_t        rsp_q;
	logic              full_q;
	logic              accept;
	logic              drain;

	// shared 33-bit adder, SUB feeds the two's complement of data_1
	assign is_sub = (req.cmd == SUB);
	assign op_0   = {1'b0, req.data_0};

	always_comb
	begin
		if (is_sub)
		begin
			op_1 = {1'b0, ~req.data_1} + 33'd1;
		end
		else
		begin
			op_1 = {1'b0, req.data_1};
		end
	end

	assign sum = op_0 + op_1;

	// overflow, add: same operand signs but result sign flips
	assign add_of = (req.data_0[DATA_W-1] == req.data_1[DATA_W-1])
		&& (req.data_0[DATA_W-1] != sum[DATA_W-1]);
	// sub: signs differ and the result leaves data_0's sign
	assign sub_of = (req.data_0[DATA_W-1] != req.data_1[DATA_W-1])
		&& (req.data_0[DATA_W-1] != sum[DATA_W-1]);

	always_comb
	begin
		arith_flags.zf = (sum[DATA_W-1:0] == '0);
		arith_flags.pf = sum[0];  // just bit 0, no real parity
		arith_flags.of = is_sub ? sub_of : add_of;
		arith_flags.sf = sum[DATA_W-1];
		arith_flags.cf = sum[DATA_W];
	end

	assign neg_data    = ~req.data_0 + 1'b1;
	assign sext8_data  = {{(DATA_W-8){req.data_1[7]}}, req.data_1[7:0]};
	assign sext16_data = {{(DATA_W-16){req.data_1[15]}}, req.data_1[15:0]};

	// comparisons, ties resolve to data_0
	assign s_ge = ($signed(req.data_0) >= $signed(req.data_1));
	assign s_le = ($signed(req.data_0) <= $signed(req.data_1));
	assign u_ge = (req.data_0 >= req.data_1);
	assign u_le = (req.data_0 <= req.data_1);

	// command decode, only ADD, SUB and COUT carry flags
	always_comb
	begin
		result = '0;  // invalid codes give all zero
		case (req.cmd)
			ADD, SUB:
			begin
				result.data  = sum[DATA_W-1:0];
				result.flags = arith_flags;
			end
			COUT:
			begin
				result.data  = {{(DATA_W-1){1'b0}}, sum[DATA_W]};
				result.flags = arith_flags;
			end
			NEG:    result.data = neg_data;
			SEXT8:  result.data = sext8_data;
			SEXT16: result.data = sext16_data;
			MAX:    result.data = s_ge ? req.data_0 : req.data_1;
			MIN:    result.data = s_le ? req.data_0 : req.data_1;
			UMAX:   result.data = u_ge ? req.data_0 : req.data_1;
			UMIN:   result.data = u_le ? req.data_0 : req.data_1;
			default:
			begin
				result = '0;
			end
		endcase
	end

	// one-entry holding register, refill allowed while draining
	assign drain    = full_q && out_ready;
	assign in_ready = !full_q || out_ready;
	assign accept   = in_valid && in_ready;

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			full_q <= 1'b0;
		end
		else if (accept)
		begin
			full_q <= 1'b1;
		end
		else if (drain)
		begin
			full_q <= 1'b0;
		end
	end

	always_ff @(posedge clock)
	begin
		if (accept)
		begin
			rsp_q <= result;
		end
	end

	assign out_valid = full_q;
	assign rsp       = rsp_q;

endmodule

// File: logic/adder_collect.sv
module adder_collect (
	input  logic                                        clock,
	input  logic                                        arst_n,
	input  logic [adder_pkg::LANES-1:0]                 lane_out_valid,
	input  adder_pkg::adder_rsp_t [adder_pkg::LANES-1:0] lane_rsp,
	output logic [adder_pkg::LANES-1:0]                 lane_out_ready,
	output logic                                        out_valid,
	output adder_pkg::adder_rsp_t                       out_rsp,
	input  logic                                        out_ready
);

	import adder_pkg::*;

	logic [LANE_W-1:0] drain_ptr;  // follows the same rotation as issue
	logic              out_fire;

	// present the lane at the pointer
	assign out_valid = lane_out_valid[drain_ptr];
	assign out_rsp   = lane_rsp[drain_ptr];
	assign out_fire  = out_valid && out_ready;

	always_comb
	begin
		lane_out_ready            = '0;
		lane_out_ready[drain_ptr] = out_ready;  // other lanes keep their result
	end

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			drain_ptr <= '0;
		end
		else if (out_fire)
		begin
			if (drain_ptr == LANE_W'(LANES - 1))
			begin
				drain_ptr <= '0;
			end
			else
			begin
				drain_ptr <= drain_ptr + 1'b1;
			end
		end
	end

endmodule

// File: logic/adder_cluster.sv
module adder_cluster (
	input  logic                  clock,
	input  logic                  arst_n,
	input  logic                  in_valid,
	input  adder_pkg::adder_req_t in_req,
	output logic                  in_ready,
	output logic                  out_valid,
	output adder_pkg::adder_rsp_t out_rsp,
	input  logic                  out_ready
);

	import adder_pkg::*;

	// dispatcher to lanes
	logic [LANES-1:0]             lane_in_valid;
	logic [LANES-1:0]             lane_in_ready;
	adder_req_t                   lane_req;  // same word to every lane

	// lanes to collector
	logic [LANES-1:0]             lane_out_valid;
	logic [LANES-1:0]             lane_out_ready;
	adder_rsp_t [LANES-1:0]       lane_rsp;

	adder_dispatch i_adder_dispatch (
		.clock         (clock),
		.arst_n        (arst_n),
		.in_valid      (in_valid),
		.in_req        (in_req),
		.in_ready      (in_ready),
		.lane_in_valid (lane_in_valid),
		.lane_req      (lane_req),
		.lane_in_ready (lane_in_ready)
	);

	for (genvar i = 0; i < LANES; i++)
	begin : g_lane
		adder_lane i_adder_lane (
			.clock     (clock),
			.arst_n    (arst_n),
			.in_valid  (lane_in_valid[i]),
			.req       (lane_req),
			.in_ready  (lane_in_ready[i]),
			.out_valid (lane_out_valid[i]),
			.rsp       (lane_rsp[i]),
			.out_ready (lane_out_ready[i])
		);
	end

	adder_collect i_adder_collect (
		.clock          (clock),
		.arst_n         (arst_n),
		.lane_out_valid (lane_out_valid),
		.lane_rsp       (lane_rsp),
		.lane_out_ready (lane_out_ready),
		.out_valid      (out_valid),
		.out_rsp        (out_rsp),
		.out_ready      (out_ready)
	);

endmodule

// File: sim/adder_cluster_checker.sv
module adder_cluster_checker (
	input logic                  clock,
	input logic                  arst_n,
	input logic                  in_ready,
	input logic                  out_valid,
	input adder_pkg::adder_rsp_t out_rsp,
	input logic                  out_ready
);

	// nothing leaves the cluster while it is held in reset
	assert property (@(posedge clock) !arst_n |-> !out_valid)
		else $error("out_valid high during reset");

	// an offered result waits unchanged until it is taken
	assert property (@(posedge clock) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_rsp))
		else $error("output result changed before it was accepted");

	assert property (@(posedge clock) $rose(arst_n) |-> in_ready)  // empty lanes take work
		else $error("in_ready low in the first cycle after reset");

endmodule

bind adder_cluster adder_cluster_checker i_adder_cluster_checker (
	.clock     (clock),
	.arst_n    (arst_n),
	.in_ready  (in_ready),
	.out_valid (out_valid),
	.out_rsp   (out_rsp),
	.out_ready (out_ready)
);

// File: sim/adder_cluster_tb.sv
module adder_cluster_tb;

	import adder_pkg::*;

	localparam int CLK_PERIOD = 100;
	localparam int NUM_CYCLES = 3000;
	localparam int WAIT_LIMIT = 40;  // cycles before a wait gives up

	logic       clock;
	logic       arst_n;
	logic       in_valid;
	adder_req_t in_req;
	logic       in_ready;
	logic       out_valid;
	adder_rsp_t out_rsp;
	logic       out_ready;

	adder_rsp_t expect_q[$];  // model results in issue order
	int         seed;
	int         roll;
	int         cycle;
	int         waited;
	int         n_checked;
	int         n_full;       // stalled cycles with every lane holding a result
	logic       pending;      // request offered but not yet taken

	adder_cluster i_adder_cluster (
		.clock     (clock),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_req    (in_req),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_rsp   (out_rsp),
		.out_ready (out_ready)
	);

	initial
	begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic abort_run(input string line);
		$display("%s", line);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped at the first error");
	endtask

	function automatic logic [DATA_W-1:0] corner_value(input int idx);
		case (idx)
			0: return 32'h0000_0000;
			1: return 32'h0000_0001;
			2: return 32'hffff_ffff;
			3: return 32'h7fff_ffff;  // largest positive
			4: return 32'h8000_0000;  // most negative
			5: return 32'h8000_0001;
			6: return 32'h0000_0080;
			7: return 32'h0000_7fff;
			8: return 32'hffff_8000;
			default: return 32'h0000_ff80;
		endcase
	endfunction

	function automatic logic [DATA_W-1:0] pick_operand();
		int r;
		r = $random(seed);
		if (r[1:0] == 2'd0)
		begin
			return corner_value(int'(r[7:4]) % 10);
		end
		return $random(seed);
	endfunction

	function automatic adder_req_t pick_request();
		adder_req_t req;
		int         r;
		r          = $random(seed);
		req.data_0 = pick_operand();
		req.data_1 = pick_operand();
		if (r[3:0] == 4'd0)
		begin
			req.data_1 = req.data_0;  // ties for the compares
		end
		if (r[6:4] == 3'd0)
		begin
			req.cmd = adder_cmd_e'(5'd10 + 5'(int'(r[15:8]) % 22));  // codes 10 to 31
		end
		else
		begin
			req.cmd = adder_cmd_e'(5'(int'(r[15:8]) % 10));
		end
		return req;
	endfunction

	// reference result, built from the command rules
	function automatic adder_rsp_t expected_rsp(input adder_req_t req);
		adder_rsp_t        e;
		logic [DATA_W-1:0] res;
		logic              carry;
		longint            s_res;  // exact signed result, no wrap
		e = '0;
		case (req.cmd)
			ADD, SUB, COUT:
			begin
				if (req.cmd == SUB)
				begin
					res   = req.data_0 - req.data_1;
					carry = (req.data_0 >= req.data_1);  // set when nothing is borrowed
					s_res = longint'($signed(req.data_0)) - longint'($signed(req.data_1));
				end
				else
				begin
					{carry, res} = {1'b0, req.data_0} + {1'b0, req.data_1};
					s_res = longint'($signed(req.data_0)) + longint'($signed(req.data_1));
				end
				e.flags.zf = (res == '0);
				e.flags.pf = res[0];
				e.flags.sf = res[DATA_W-1];
				e.flags.cf = carry;
				e.flags.of = (s_res > 64'sd2147483647) || (s_res < -64'sd2147483648);
				e.data     = (req.cmd == COUT) ? 32'(carry) : res;
			end
			NEG:     e.data = 32'd0 - req.data_0;
			SEXT8:   e.data = 32'($signed(req.data_1[7:0]));
			SEXT16:  e.data = 32'($signed(req.data_1[15:0]));
			MAX:     e.data = ($signed(req.data_1) > $signed(req.data_0)) ? req.data_1 : req.data_0;
			MIN:     e.data = ($signed(req.data_1) < $signed(req.data_0)) ? req.data_1 : req.data_0;
			UMAX:    e.data = (req.data_1 > req.data_0) ? req.data_1 : req.data_0;
			UMIN:    e.data = (req.data_1 < req.data_0) ? req.data_1 : req.data_0;
			default: e = '0;
		endcase
		return e;
	endfunction

	// one clock cycle, entered and left at a falling edge
	task automatic run_cycle(input logic offer, input logic take);
		int n;
		n = expect_q.size();
		if (!pending)
		begin
			in_valid = offer;
			if (offer)
			begin
				in_req = pick_request();
			end
		end
		out_ready = take;
		#(CLK_PERIOD / 4);  // sample well clear of both edges
		assert (in_ready == ((n < LANES) || take)) else abort_run($sformatf(
			"FAILED at time %0t: in_ready is %b with %0d results in flight", $time, in_ready, n));
		assert (out_valid == (n > 0)) else abort_run($sformatf(
			"FAILED at time %0t: out_valid is %b with %0d results in flight", $time, out_valid, n));
		if (n == LANES && !take)
		begin
			n_full++;
		end
		if (out_valid && out_ready)
		begin
			assert (out_rsp == expect_q[0]) else abort_run($sformatf(
				"FAILED at time %0t: result %0d is %h, expected %h",
				$time, n_checked, out_rsp, expect_q[0]));
			void'(expect_q.pop_front());
			n_checked++;
		end
		if (in_valid && in_ready)
		begin
			expect_q.push_back(expected_rsp(in_req));
		end
		pending = in_valid && !in_ready;  // hold the request until it is taken
		@(negedge clock);
	endtask

	initial
	begin
		seed      = 32'hb2e5;
		arst_n    = 1'b0;
		in_valid  = 1'b0;
		in_req    = '0;
		out_ready = 1'b0;
		pending   = 1'b0;
		n_checked = 0;
		n_full    = 0;
		repeat (2) @(posedge clock);
		@(negedge clock);
		arst_n = 1'b1;

		// idle cluster, one request, result one cycle after the handshake
		run_cycle(1'b1, 1'b1);
		run_cycle(1'b0, 1'b1);

		for (cycle = 0; cycle < NUM_CYCLES; cycle++)
		begin
			roll = $random(seed);
			if (cycle % 200 < 12)
			begin
				run_cycle(roll[2:0] != 3'd0, 1'b0);  // output stalled, lanes fill up
			end
			else
			begin
				run_cycle(roll[1:0] != 2'd0, roll[5:4] != 2'd0);
			end
		end

		waited = 0;
		while ((expect_q.size() > 0 || pending) && waited < WAIT_LIMIT)
		begin
			run_cycle(1'b0, 1'b1);
			waited++;
		end
		assert (expect_q.size() == 0 && !pending)
			else abort_run("timeout while draining the results left in the cluster");
		assert (n_full > 0) else abort_run("all four lanes were never seen full at once");
		$display("%0d results checked", n_checked);
		$display("*** PASSED ***");
		$finish;
	end

endmodule

// File: flist.f
logic/adder_pkg.sv
logic/adder_dispatch.sv
logic/adder_lane.sv
logic/adder_collect.sv
logic/adder_cluster.sv
sim/adder_cluster_checker.sv
sim/adder_cluster_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= adder_cluster_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing --assert -Wall
PASS_TEXT ?= *** PASSED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# the run passes only when the pass line shows up in the output
run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF '$(PASS_TEXT)'

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR)
